//--- icache.f
hw/icache_pkg.sv
hw/icache_control_ram.sv
hw/cache_data_ram.sv
hw/icache_matched.sv
hw/icache_read.sv
hw/icache.sv
bench/tb_icache.sv

//--- Makefile
.PHONY: all run clean

all: run

obj_dir/Vtb_icache: icache.f $(wildcard hw/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_icache \
		-f icache.f -o Vtb_icache

# pass only when the testbench prints its pass line
run: obj_dir/Vtb_icache
	./obj_dir/Vtb_icache | tee /dev/stderr | grep -x "test passed" > /dev/null

clean:
	rm -rf obj_dir

//--- bench/tb_icache.sv
`timescale 1ns/100ps

module tb_icache
    import icache_pkg::*;
();

    localparam int SET_BITS  = 2;              // 4 sets, evictions come quickly
    localparam int SETS      = 1 << SET_BITS;
    localparam int POOL_SIZE = 24;
    localparam int OPS       = 400;
    localparam int TIMEOUT   = 40;             // cycles per wait loop

    logic       clk;
    logic       rst_n;
    logic       icacheread_do;
    addr_t      icacheread_address;
    fetch_len_t icacheread_length;
    logic       icacheread_cache_disable;
    logic       readcode_do;
    addr_t      readcode_address;
    logic       readcode_done;
    line_t      readcode_line;
    logic       dcachetoicache_accept_do;
    addr_t      dcachetoicache_accept_address;
    logic       dcachetoicache_accept_empty;
    logic       prefetchfifo_write_do;
    prefetch_t  prefetchfifo_write_data;
    logic       prefetched_do;
    fetch_len_t prefetched_length;
    logic       invdcode_do;
    logic       invdcode_done;

    // reference model of the cache
    logic [3:0] model_valid [SETS];
    line_addr_t model_tag   [SETS][4];
    logic [2:0] model_plru  [SETS];        // {p2, p1, p0}
    line_addr_t pool        [POOL_SIZE];

    integer     seed;
    int         hits, misses, evictions, snoops, sweeps;
    int         mem_delay_next;            // drawn before each fetch
    int         mem_delay;
    logic       mem_busy;
    line_addr_t mem_line;

    icache #(.SET_BITS(SET_BITS)) uut (
        .clk                           (clk),
        .rst_n                         (rst_n),
        .icacheread_do                 (icacheread_do),
        .icacheread_address            (icacheread_address),
        .icacheread_length             (icacheread_length),
        .icacheread_cache_disable      (icacheread_cache_disable),
        .readcode_do                   (readcode_do),
        .readcode_address              (readcode_address),
        .readcode_done                 (readcode_done),
        .readcode_line                 (readcode_line),
        .dcachetoicache_accept_do      (dcachetoicache_accept_do),
        .dcachetoicache_accept_address (dcachetoicache_accept_address),
        .dcachetoicache_accept_empty   (dcachetoicache_accept_empty),
        .prefetchfifo_write_do         (prefetchfifo_write_do),
        .prefetchfifo_write_data       (prefetchfifo_write_data),
        .prefetched_do                 (prefetched_do),
        .prefetched_length             (prefetched_length),
        .invdcode_do                   (invdcode_do),
        .invdcode_done                 (invdcode_done)
    );

    always #20 clk = ~clk;

    // ------------------------------
    // memory responder
    // ------------------------------
    always @(posedge clk) begin
        readcode_done <= 1'b0;
        if (mem_busy) begin
            if (mem_delay == 1) begin
                readcode_done <= 1'b1;
                readcode_line <= line_of(mem_line);
                mem_busy      <= 1'b0;
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end else if (readcode_do) begin
            mem_busy  <= 1'b1;
            mem_line  <= readcode_address[31:4];
            mem_delay <= mem_delay_next;   // 1..6
        end
    end

    // line contents as a function of the whole line address
    function automatic line_t line_of(line_addr_t la);
        line_t l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[8*b +: 8] = la[7:0] ^ la[15:8] ^ la[23:16] ^ {4'h0, la[27:24]} ^ 8'(b * 37 + 5);
        end
        return l;
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    // requested byte first, count of bytes to line end on top
    function automatic prefetch_t rotate_line(line_t l, int off);
        line_t r;
        for (int i = 0; i < LINE_BYTES; i++) begin
            r[8*i +: 8] = l[8*((off + i) % LINE_BYTES) +: 8];
        end
        return {8'(LINE_BYTES - off), r};
    endfunction

    // way holding the line, -1 if none
    function automatic int find_way(line_addr_t la);
        int s;
        s = int'(la[SET_BITS-1:0]);
        for (int w = 0; w < 4; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == la) return w;
        end
        return -1;
    endfunction

    function automatic int victim_way(int s);
        for (int w = 0; w < 4; w++) begin
            if (!model_valid[s][w]) return w;   // free way first
        end
        if (model_plru[s][0]) return model_plru[s][2] ? 3 : 2;
        return model_plru[s][1] ? 1 : 0;
    endfunction

    task automatic touch(int s, int w);
        model_plru[s][0] = (w < 2);             // other pair
        if (w < 2) begin
            model_plru[s][1] = (w == 0);        // other way of pair 0/1
        end else begin
            model_plru[s][2] = (w == 2);
        end
    endtask

    // ------------------------------
    // checks
    // ------------------------------
    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_prefetch(string name, prefetch_t got, prefetch_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_len(string name, fetch_len_t got, fetch_len_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------
    // operations
    // ------------------------------
    task automatic fetch(line_addr_t la, int off, int len, logic no_cache);
        int   s, w, n, mem_seen, lim;
        logic expect_hit;
        s          = int'(la[SET_BITS-1:0]);
        w          = find_way(la);
        expect_hit = !no_cache && (w >= 0);    // uncached never hits
        n          = 0;
        mem_seen   = 0;
        lim        = LINE_BYTES - off;
        if (len < lim) lim = len;
        mem_delay_next = 1 + rand_below(6);
        @(posedge clk);
        icacheread_do            <= 1'b1;
        icacheread_address       <= {la, 4'(off)};
        icacheread_length        <= fetch_len_t'(len);
        icacheread_cache_disable <= no_cache;
        do begin
            @(negedge clk);
            n++;
            if (readcode_do) begin
                if (expect_hit) begin
                    $display("memory read issued for a line that should hit");
                    abort_run();
                end
                mem_seen++;
                compare_addr("readcode_address", readcode_address, {la, 4'h0});
            end
            if (n > TIMEOUT) begin
                $display("timeout waiting for prefetched_do");
                abort_run();
            end
        end while (!prefetched_do);
        if (expect_hit && n != 2) begin
            $display("hit result not one cycle after the request was sampled");
            abort_run();
        end
        if (!expect_hit && mem_seen != 1) begin
            $display("miss finished without exactly one memory read");
            abort_run();
        end
        if (!expect_hit && !readcode_done) begin
            $display("miss result not in the cycle of readcode_done");
            abort_run();
        end
        if (!prefetchfifo_write_do) begin
            $display("prefetched_do came without a FIFO write");
            abort_run();
        end
        compare_prefetch("prefetchfifo_write_data", prefetchfifo_write_data,
                         rotate_line(line_of(la), off));
        compare_len("prefetched_length", prefetched_length, fetch_len_t'(lim));
        if (expect_hit) begin
            hits++;
            touch(s, w);
        end else begin
            misses++;
            if (!no_cache) begin
                w = victim_way(s);
                if (model_valid[s][w]) evictions++;
                model_valid[s][w] = 1'b1;
                model_tag[s][w]   = la;
                touch(s, w);
            end
        end
        @(posedge clk);
        icacheread_do <= 1'b0;
    endtask

    task automatic snoop(line_addr_t la, int off);
        int n, w;
        n = 0;
        @(posedge clk);
        dcachetoicache_accept_empty   <= 1'b0;
        dcachetoicache_accept_address <= {la, 4'(off)};
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("timeout waiting for dcachetoicache_accept_do");
                abort_run();
            end
        end while (!dcachetoicache_accept_do);
        @(posedge clk);
        dcachetoicache_accept_empty <= 1'b1;
        @(negedge clk);
        if (dcachetoicache_accept_do) begin
            $display("snoop accept strobe longer than one cycle");
            abort_run();
        end
        w = find_way(la);
        if (w >= 0) model_valid[int'(la[SET_BITS-1:0])][w] = 1'b0;   // pLRU untouched
        snoops++;
    endtask

    task automatic invalidate_all();
        int n;
        n = 0;
        @(posedge clk);
        invdcode_do <= 1'b1;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("timeout waiting for invdcode_done");
                abort_run();
            end
        end while (!invdcode_done);
        if (n != SETS) begin
            $display("invalidate sweep did not take one cycle per set");
            abort_run();
        end
        @(posedge clk);
        invdcode_do <= 1'b0;
        for (int s = 0; s < SETS; s++) begin
            model_valid[s] = 4'b0000;
            model_plru[s]  = 3'b000;       // whole control word cleared
        end
        sweeps++;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int         pick, off;
        line_addr_t la;
        clk                           = 1'b0;
        rst_n                         = 1'b0;
        icacheread_do                 = 1'b0;
        icacheread_address            = '0;
        icacheread_length             = '0;
        icacheread_cache_disable      = 1'b0;
        readcode_done                 = 1'b0;
        readcode_line                 = '0;
        dcachetoicache_accept_address = '0;
        dcachetoicache_accept_empty   = 1'b1;
        invdcode_do                   = 1'b0;
        mem_busy                      = 1'b0;
        mem_delay                     = 0;
        mem_delay_next                = 1;
        mem_line                      = '0;
        seed                          = 32'h90d5_6d2e;
        hits      = 0;
        misses    = 0;
        evictions = 0;
        snoops    = 0;
        sweeps    = 0;
        for (int s = 0; s < SETS; s++) begin
            model_valid[s] = 4'b0000;
            model_plru[s]  = 3'b000;
        end
        // distinct low bits, 6 lines per set
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = (line_addr_t'($random(seed)) & 28'hfff_ff00) | line_addr_t'(i);
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (readcode_do || prefetched_do || prefetchfifo_write_do ||
            dcachetoicache_accept_do || invdcode_done) begin
            $display("strobe high right after reset");
            abort_run();
        end
        for (int i = 0; i < OPS; i++) begin
            pick = rand_below(100);
            la   = pool[rand_below(POOL_SIZE)];
            off  = rand_below(LINE_BYTES);
            if (pick < 3) begin
                invalidate_all();
            end else if (pick < 15) begin
                snoop(la, off);
            end else begin
                fetch(la, off, 1 + rand_below(LINE_BYTES), pick < 27);   // some uncached
            end
        end
        if (hits == 0 || misses == 0 || evictions == 0 || snoops == 0 || sweeps == 0) begin
            $display("random run missed a kind of operation");
            abort_run();
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- hw/icache.sv
`timescale 1ns/100ps

module icache
    import icache_pkg::*;
#(
    parameter int SET_BITS = 5
) (
    input  logic       clk,
    input  logic       rst_n,

    // fetch request, level until prefetched_do
    input  logic       icacheread_do,
    input  addr_t      icacheread_address,
    input  fetch_len_t icacheread_length,
    input  logic       icacheread_cache_disable,

    // memory line read
    output logic       readcode_do,
    output addr_t      readcode_address,
    input  logic       readcode_done,
    input  line_t      readcode_line,

    // write snoop from the data cache
    output logic       dcachetoicache_accept_do,
    input  addr_t      dcachetoicache_accept_address,
    input  logic       dcachetoicache_accept_empty,

    output logic       prefetchfifo_write_do,
    output prefetch_t  prefetchfifo_write_data,

    output logic       prefetched_do,
    output fetch_len_t prefetched_length,

    input  logic       invdcode_do,
    output logic       invdcode_done
);

    icache_state_t state;
    addr_t         address;         // saved request or snoop address
    fetch_len_t    length;
    logic          cache_disable;

    addr_t      ram_address;
    logic       ram_read_do;
    logic       snoop_take;
    logic       read_take;
    logic       hit;
    logic       fill_done;
    logic       ctrl_write_do;
    ctrl_t      ctrl_data;
    ctrl_t      ctrl_q;
    logic [3:0] data_write_do;
    entry_t     data_q0, data_q1, data_q2, data_q3;

    logic       matched;
    line_t      matched_data_line;
    way_t       plru_index;
    ctrl_t      ctrl_after_invalidate_write;
    ctrl_t      ctrl_after_match;
    ctrl_t      ctrl_after_line_read;
    prefetch_t  hit_prefetch, fill_prefetch;
    fetch_len_t hit_length, fill_length;

    // ------------------------------
    // idle decisions and RAM reads
    // ------------------------------
    // invalidate all first, then snoop, then fetch
    assign snoop_take = (state == state_idle) && !invdcode_do && !dcachetoicache_accept_empty;
    assign read_take  = (state == state_idle) && !invdcode_do && dcachetoicache_accept_empty &&
                        icacheread_do && (icacheread_length != '0);

    assign ram_read_do = snoop_take || read_take;
    assign ram_address = (state != state_idle)      ? address :
                         dcachetoicache_accept_empty ? icacheread_address :
                                                       dcachetoicache_accept_address;

    assign dcachetoicache_accept_do = snoop_take;

    // ------------------------------
    // check and fill
    // ------------------------------
    assign hit       = (state == state_check) && matched && !cache_disable;  // uncached always misses
    assign fill_done = (state == state_read) && readcode_done;

    assign readcode_do      = (state == state_check) && !hit;
    assign readcode_address = {address[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    assign prefetchfifo_write_do   = hit || fill_done;
    assign prefetchfifo_write_data = hit ? hit_prefetch : fill_prefetch;
    assign prefetched_do           = hit || fill_done;
    assign prefetched_length       = hit ? hit_length : fill_length;

    assign ctrl_write_do = (state == state_invalidate_write) || hit || (fill_done && !cache_disable);

    always_comb begin
        ctrl_data = ctrl_after_line_read;   // fill: victim valid, pLRU moved
        if (state == state_invalidate_write) begin
            ctrl_data = ctrl_after_invalidate_write;
        end else if (hit) begin
            ctrl_data = ctrl_after_match;
        end
    end

    // cached fill goes into the victim way
    assign data_write_do = (fill_done && !cache_disable) ? (4'b0001 << plru_index) : 4'b0000;

    // ------------------------------
    // state and saved request
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= state_idle;
        end else begin
            case (state)
                state_idle: begin
                    if (snoop_take)     state <= state_invalidate_write;
                    else if (read_take) state <= state_check;
                end
                state_invalidate_write: state <= state_idle;
                state_check:            state <= hit ? state_idle : state_read;
                state_read: begin
                    if (readcode_done) state <= state_idle;
                end
                default:                state <= state_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ram_read_do) begin
            address <= ram_address;
        end
        if (read_take) begin
            length        <= icacheread_length;
            cache_disable <= icacheread_cache_disable;
        end
    end

    // ------------------------------
    // RAMs and helpers
    // ------------------------------
    icache_control_ram #(.SET_BITS(SET_BITS)) icache_control_ram_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .address       (ram_address),
        .read_do       (ram_read_do),
        .q             (ctrl_q),
        .write_do      (ctrl_write_do),
        .data          (ctrl_data),
        .invdcode_do   (invdcode_do && (state == state_idle)),  // sweep only from idle
        .invdcode_done (invdcode_done)
    );

    cache_data_ram #(.SET_BITS(SET_BITS)) cache_data_ram0 (
        .clk (clk), .rst_n (rst_n), .address (ram_address), .read_do (ram_read_do),
        .q (data_q0), .write_do (data_write_do[0]), .data (readcode_line)
    );

    cache_data_ram #(.SET_BITS(SET_BITS)) cache_data_ram1 (
        .clk (clk), .rst_n (rst_n), .address (ram_address), .read_do (ram_read_do),
        .q (data_q1), .write_do (data_write_do[1]), .data (readcode_line)
    );

    cache_data_ram #(.SET_BITS(SET_BITS)) cache_data_ram2 (
        .clk (clk), .rst_n (rst_n), .address (ram_address), .read_do (ram_read_do),
        .q (data_q2), .write_do (data_write_do[2]), .data (readcode_line)
    );

    cache_data_ram #(.SET_BITS(SET_BITS)) cache_data_ram3 (
        .clk (clk), .rst_n (rst_n), .address (ram_address), .read_do (ram_read_do),
        .q (data_q3), .write_do (data_write_do[3]), .data (readcode_line)
    );

    icache_matched #(.SET_BITS(SET_BITS)) icache_matched_inst (
        .address                        (address),
        .control                        (ctrl_q),
        .data_0                         (data_q0),
        .data_1                         (data_q1),
        .data_2                         (data_q2),
        .data_3                         (data_q3),
        .matched                        (matched),
        .matched_data_line              (matched_data_line),
        .plru_index                     (plru_index),
        .control_after_invalidate_write (ctrl_after_invalidate_write),
        .control_after_match            (ctrl_after_match),
        .control_after_line_read        (ctrl_after_line_read)
    );

    // hit path, line from the data RAMs
    icache_read icache_read_hit (
        .line            (matched_data_line),
        .address         (address),
        .length          (length),
        .prefetch        (hit_prefetch),
        .prefetch_length (hit_length)
    );

    // miss path, line straight from memory
    icache_read icache_read_fill (
        .line            (readcode_line),
        .address         (address),
        .length          (length),
        .prefetch        (fill_prefetch),
        .prefetch_length (fill_length)
    );

    // memory is asked only in check, the cycle after a request was sampled
    assert property (@(posedge clk) disable iff (!rst_n)
        readcode_do |-> $past(read_take))
        else $error("icache: readcode_do outside check");

    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(data_write_do))
        else $error("icache: more than one way written");

endmodule

//--- hw/icache_read.sv
`timescale 1ns/100ps

module icache_read
    import icache_pkg::*;
(
    input  line_t      line,
    input  addr_t      address,
    input  fetch_len_t length,          // bytes wanted by the prefetcher

    output prefetch_t  prefetch,
    output fetch_len_t prefetch_length
);

    localparam int LINE_BITS = $bits(line_t);

    logic [OFFSET_BITS-1:0] offset;
    logic [2*LINE_BITS-1:0] doubled;    // two copies make the shift a rotate
    fetch_len_t             remaining;  // bytes from the offset to line end

    assign offset    = address[OFFSET_BITS-1:0];
    assign doubled   = {line, line} >> {offset, 3'b000};
    assign remaining = fetch_len_t'(LINE_BYTES) - fetch_len_t'(offset);

    // requested byte lands in byte 0
    assign prefetch = {3'b000, remaining, doubled[LINE_BITS-1:0]};

    // page or segment limit can cut the fetch short
    assign prefetch_length = (length < remaining) ? length : remaining;

endmodule

//--- hw/icache_matched.sv
`timescale 1ns/100ps

module icache_matched
    import icache_pkg::*;
#(
    parameter int SET_BITS = 5
) (
    input  addr_t  address,
    input  ctrl_t  control,

    input  entry_t data_0,
    input  entry_t data_1,
    input  entry_t data_2,
    input  entry_t data_3,

    output logic   matched,
    output line_t  matched_data_line,

    output way_t   plru_index,     // victim for a fill

    output ctrl_t  control_after_invalidate_write,
    output ctrl_t  control_after_match,
    output ctrl_t  control_after_line_read
);

    // index bits equal by construction, only the tag part is compared
    localparam int TAG_LSB       = OFFSET_BITS + SET_BITS;
    localparam int ENTRY_TAG_LSB = $bits(line_t) + SET_BITS;

    entry_t     ways [4];
    logic [3:0] valid;
    logic [3:0] hit;
    way_t       match_index;
    ctrl_t      control_filled;

    // point the tree away from the accessed way
    function automatic ctrl_t plru_touch(ctrl_t c, way_t w);
        ctrl_t r;
        r    = c;
        r[4] = ~w[1];       // p0 to the other pair
        if (w[1]) begin
            r[6] = ~w[0];   // p2
        end else begin
            r[5] = ~w[0];   // p1
        end
        return r;
    endfunction

    assign ways[0] = data_0;
    assign ways[1] = data_1;
    assign ways[2] = data_2;
    assign ways[3] = data_3;

    assign valid = control[3:0];

    // ------------------------------
    // compare and select
    // ------------------------------
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            hit[w] = valid[w] &&
                (ways[w][$bits(entry_t)-1:ENTRY_TAG_LSB] == address[$bits(addr_t)-1:TAG_LSB]);
        end
    end

    assign matched     = |hit;
    assign match_index = hit[3] ? 2'd3 : hit[2] ? 2'd2 : hit[1] ? 2'd1 : 2'd0;

    assign matched_data_line = ways[match_index][$bits(line_t)-1:0];

    // victim: lowest invalid way, otherwise walk the tree
    always_comb begin
        if (!valid[0])      plru_index = 2'd0;
        else if (!valid[1]) plru_index = 2'd1;
        else if (!valid[2]) plru_index = 2'd2;
        else if (!valid[3]) plru_index = 2'd3;
        else if (control[4]) plru_index = {1'b1, control[6]};  // pair 2/3
        else                plru_index = {1'b0, control[5]};   // pair 0/1
    end

    // ------------------------------
    // next control words
    // ------------------------------
    assign control_after_invalidate_write = control & ~{3'b000, hit};  // snoop drops the way
    assign control_after_match            = plru_touch(control, match_index);

    always_comb begin
        control_filled             = control;
        control_filled[plru_index] = 1'b1;  // victim valid again
    end

    assign control_after_line_read = plru_touch(control_filled, plru_index);

    // a line lives in one way only, fills happen on a miss
    always_comb begin
        assert ($onehot0(hit))
            else $error("icache_matched: line present in more than one way");
    end

endmodule

//--- hw/cache_data_ram.sv
`timescale 1ns/100ps

module cache_data_ram
    import icache_pkg::*;
#(
    parameter int SET_BITS = 5
) (
    input  logic   clk,
    input  logic   rst_n,

    input  addr_t  address,

    input  logic   read_do,
    output entry_t q,           // {line address, line}

    input  logic   write_do,
    input  line_t  data
);

    localparam int SETS = 1 << SET_BITS;

    entry_t              mem [SETS];
    logic [SET_BITS-1:0] index;
    line_addr_t          line_address;

    assign index        = address[OFFSET_BITS +: SET_BITS];
    assign line_address = address[$bits(addr_t)-1:OFFSET_BITS];

    // line storage, validity kept in the control RAM
    always_ff @(posedge clk) begin
        if (write_do) begin
            mem[index] <= {line_address, data};
        end
    end

    // read register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (read_do) begin
            q <= mem[index];    // reads and writes never share a cycle
        end
    end

endmodule

//--- hw/icache_control_ram.sv
`timescale 1ns/100ps

module icache_control_ram
    import icache_pkg::*;
#(
    parameter int SET_BITS = 5
) (
    input  logic  clk,
    input  logic  rst_n,

    input  addr_t address,

    input  logic  read_do,
    output ctrl_t q,

    input  logic  write_do,
    input  ctrl_t data,

    input  logic  invdcode_do,      // held while the sweep runs
    output logic  invdcode_done
);

    localparam int SETS = 1 << SET_BITS;

    typedef logic [SET_BITS-1:0] set_t;

    ctrl_t mem [SETS];
    set_t  index;
    set_t  sweep_count;     // set cleared in this cycle
    logic  sweep_last;

    assign index      = address[OFFSET_BITS +: SET_BITS];
    assign sweep_last = (sweep_count == set_t'(SETS - 1));

    // done with the clear of the last set
    assign invdcode_done = invdcode_do && sweep_last;

    // ------------------------------
    // storage, write port and sweep
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SETS; i++) begin
                mem[i] <= '0;               // all ways invalid
            end
            sweep_count <= '0;
        end else if (invdcode_do) begin
            mem[sweep_count] <= '0;         // one set per cycle
            sweep_count      <= sweep_count + 1'b1;  // wraps to 0 after the last set
        end else begin
            sweep_count <= '0;
            if (write_do) begin
                mem[index] <= data;
            end
        end
    end

    // registered read, held until the next read_do
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (read_do) begin
            q <= mem[index];
        end
    end

    // the top only sweeps from idle, where no control write is issued
    assert property (@(posedge clk) disable iff (!rst_n)
        invdcode_do |-> !write_do)
        else $error("icache_control_ram: write during invalidate sweep");

endmodule

//--- hw/icache_pkg.sv
package icache_pkg;

    // ------------------------------
    // line geometry
    // ------------------------------
    localparam int LINE_BYTES  = 16;
    localparam int OFFSET_BITS = 4;    // log2 of LINE_BYTES

    // ------------------------------
    // vector types
    // ------------------------------
    typedef logic [31:0]  addr_t;        // byte address
    typedef logic [27:0]  line_addr_t;   // address without the byte offset
    typedef logic [127:0] line_t;        // byte 0 in bits 7:0

    // data RAM word: {line address, line}
    typedef logic [$bits(line_addr_t)+$bits(line_t)-1:0] entry_t;

    // per-set control word
    //   [3:0] valid of ways 3..0
    //   [4] p0, pair select
    //   [5] p1, way inside pair 0/1
    //   [6] p2, way inside pair 2/3
    typedef logic [6:0] ctrl_t;

    typedef logic [1:0] way_t;
    typedef logic [4:0] fetch_len_t;     // 0..16 bytes

    // prefetch FIFO entry: {valid byte count, rotated line}
    typedef logic [135:0] prefetch_t;

    // ------------------------------
    // top level FSM
    // ------------------------------
    typedef enum logic [1:0] {
        state_idle,
        state_invalidate_write,     // second half of a snoop
        state_check,                // RAM outputs valid, hit or miss decided
        state_read                  // waiting for the memory line
    } icache_state_t;

endpackage
